// File: testbench/stacker_patterns.txt
# test <name> <pattern 0 bars 1 gradient 2 checker 3 solid> <credits 0 immediate 1 random 2 stall>
# chunk <chunk number> <expected chunk data in hex, lane 7 first>, then run
test bars_immediate 0 0
chunk 0 00000000000000000000000000000000
chunk 107 f81ff81ff81ff81ff81ff81ff81ff81f
chunk 3613 07e007e007e007e007e007e007e007e0
chunk 7199 ffffffffffffffffffffffffffffffff
run
test gradient_immediate 1 0
chunk 1234 10e010e010e010e010e010e010e010e0
chunk 5000 03e003e003e003e003e003e003e003e0
chunk 7199 3d803d803d803d803d803d803d803d80
run
test checker_immediate 2 0
chunk 2 ffffffffffffffffffffffffffffffff
chunk 650 00000000000000000000000000000000
chunk 1287 ffffffffffffffffffffffffffffffff
chunk 7199 00000000000000000000000000000000
run
test solid_stall 3 2
chunk 0 f800f800f800f800f800f800f800f800
chunk 2021 f800f800f800f800f800f800f800f800
chunk 7199 f800f800f800f800f800f800f800f800
run
test bars_random 0 1
chunk 15 07ff07ff07ff07ff07ff07ff07ff07ff
chunk 4024 f800f800f800f800f800f800f800f800
chunk 7199 ffffffffffffffffffffffffffffffff
run
test gradient_random 1 1
chunk 317 28202820282028202820282028202820
chunk 5000 03e003e003e003e003e003e003e003e0
run

// File: project.f
+incdir+design
design/stacker_pkg.sv
design/chunk_scanner.sv
design/pattern_lane.sv
design/chunk_assembler.sv
design/pattern_stacker.sv
testbench/tb_pattern_stacker.sv

// File: Bender.yml
package:
  name: pattern_stacker

sources:
  - include_dirs:
      - design
    files:
      - design/stacker_pkg.sv
      - design/chunk_scanner.sv
      - design/pattern_lane.sv
      - design/chunk_assembler.sv
      - design/pattern_stacker.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_pattern_stacker.sv

// File: testbench/tb_pattern_stacker.sv
// self-checking testbench for the pattern stacker, runs the frames listed in the pattern file
`include "stacker_defines.svh"

module tb_pattern_stacker;

  // sink withholds credits this long in stall mode
  localparam int STALL_CYCLES  = 24;
  // idle cycles watched after the final chunk
  localparam int TAIL_CYCLES   = 8;
  // chunk count at which a second start is pulsed
  localparam int BUSY_START_AT = 100;
  // start to first chunk, one cycle to issue and two through the pipeline
  localparam int FIRST_LATENCY = 3;

  logic                     clk_camera;
  logic                     recent_reset;
  logic                     start;
  stacker_pkg::pattern_e    pattern_sel;
  logic                     credit_return;
  logic                     chunk_valid;
  stacker_pkg::chunk_t      chunk_data;
  stacker_pkg::chunk_addr_t chunk_addr;
  logic                     chunk_last;
  logic                     frame_done;
  logic                     busy;

  int          cycle_count  = 0;
  int          deadline     = 1000;
  int          test_errors  = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  logic [31:0] rng_state;
  string       test_name;

  // sampled chunks of the current test
  stacker_pkg::chunk_addr_t sample_addr [$];
  stacker_pkg::chunk_t      sample_data [$];

  initial clk_camera = 1'b0;
  always #4 clk_camera = ~clk_camera;

  always @(posedge clk_camera) begin
    cycle_count <= cycle_count + 1;
  end

  pattern_stacker dut0 (
    .clk_camera      (clk_camera),
    .recent_reset    (recent_reset),
    .start_i         (start),
    .pattern_sel_i   (pattern_sel),
    .credit_return_i (credit_return),
    .chunk_valid_o   (chunk_valid),
    .chunk_data_o    (chunk_data),
    .chunk_addr_o    (chunk_addr),
    .chunk_last_o    (chunk_last),
    .frame_done_o    (frame_done),
    .busy_o          (busy)
  );

  task automatic check_chunk(input string what, input stacker_pkg::chunk_t exp,
                             input stacker_pkg::chunk_t act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_addr(input string what, input stacker_pkg::chunk_addr_t exp,
                            input stacker_pkg::chunk_addr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // no output activity before any start
  task automatic check_idle();
    check_flag("chunk_valid idle", 1'b0, chunk_valid);
    check_flag("chunk_last idle", 1'b0, chunk_last);
    check_flag("frame_done idle", 1'b0, frame_done);
    check_flag("busy idle", 1'b0, busy);
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s finished: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s finished: %0d errors", test_name, test_errors);
    end
  endtask

  // one frame, sampled and driven on the falling edge
  // credit mode 0 immediate, 1 random delay, 2 withheld at first
  task automatic run_frame(input stacker_pkg::pattern_e pat, input int mode);
    int cyc;
    int received;
    int returned;
    int pending;
    int wait_left;
    int tail;
    int matched;
    int i;
    bit restarted;
    bit last_seen;
    cyc       = 0;
    received  = 0;
    returned  = 0;
    pending   = 0;
    wait_left = 0;
    tail      = 0;
    matched   = 0;
    restarted = 1'b0;
    last_seen = 1'b0;
    deadline  = cycle_count + `CHUNKS_PER_FRAME * 10 + 500;
    start       = 1'b1;
    pattern_sel = pat;
    while (received < `CHUNKS_PER_FRAME || tail < TAIL_CYCLES || pending != 0) begin
      @(negedge clk_camera);
      cyc++;
      start = 1'b0;
      if (last_seen) begin
        check_flag("busy after last chunk", 1'b0, busy);
        last_seen = 1'b0;
      end
      if (chunk_valid) begin
        if (received >= `CHUNKS_PER_FRAME) begin
          $display("[ERROR] %s: chunk %0d arrived after the frame had ended",
                   test_name, chunk_addr);
          test_errors++;
        end else begin
          if (received == 0) begin
            check_count("first chunk latency", FIRST_LATENCY, cyc);
          end
          check_addr("chunk number", stacker_pkg::chunk_addr_t'(received), chunk_addr);
          check_flag("chunk_last", received == `CHUNKS_PER_FRAME - 1, chunk_last);
          check_flag("frame_done", received == `CHUNKS_PER_FRAME - 1, frame_done);
          check_flag("busy during frame", 1'b1, busy);
          for (i = 0; i < sample_addr.size(); i++) begin
            if (sample_addr[i] == stacker_pkg::chunk_addr_t'(received)) begin
              check_chunk("chunk data", sample_data[i], chunk_data);
              matched++;
            end
          end
          last_seen = received == `CHUNKS_PER_FRAME - 1;
          received++;
          pending++;
          if (received - returned > `CHUNK_CREDITS) begin
            $display("[ERROR] %s: %0d chunks outstanding, more than the %0d credits",
                     test_name, received - returned, `CHUNK_CREDITS);
            test_errors++;
          end
        end
      end else begin
        check_flag("chunk_last without chunk", 1'b0, chunk_last);
        check_flag("frame_done without chunk", 1'b0, frame_done);
      end
      if (received >= `CHUNKS_PER_FRAME) begin
        tail++;
      end
      // output must have stopped at the credit limit
      if (mode == 2 && cyc == STALL_CYCLES) begin
        check_count("chunks during credit stall", `CHUNK_CREDITS, received);
      end
      // credit sink, one credit per cycle at most
      credit_return = 1'b0;
      if (pending > 0 && !(mode == 2 && cyc < STALL_CYCLES)) begin
        if (wait_left == 0) begin
          credit_return = 1'b1;
          pending--;
          returned++;
          if (mode == 1) begin
            rng_state = xorshift32(rng_state);
            wait_left = int'(rng_state[2:0]);
          end
        end else begin
          wait_left--;
        end
      end
      // start while busy, with another pattern
      if (received == BUSY_START_AT && !restarted) begin
        start       = 1'b1;
        pattern_sel = stacker_pkg::pattern_e'(pat ^ 2'd1);
        restarted   = 1'b1;
      end
    end
    @(negedge clk_camera);
    credit_return = 1'b0;
    check_count("chunks in frame", `CHUNKS_PER_FRAME, received);
    check_count("sampled chunks checked", sample_addr.size(), matched);
  endtask

  initial begin : main_seq
    int                  fd;
    int                  n;
    int                  pat_code;
    int                  mode;
    int                  addr;
    stacker_pkg::chunk_t exp_data;
    string               kw;
    rng_state     = 32'h4428;
    recent_reset  = 1'b1;
    start         = 1'b0;
    pattern_sel   = stacker_pkg::PAT_BARS;
    credit_return = 1'b0;
    test_name     = "reset";
    repeat (16) begin
      @(negedge clk_camera);
      check_idle();
    end
    recent_reset = 1'b0;
    repeat (4) begin
      @(negedge clk_camera);
      check_idle();
    end
    report_test();
    fd = $fopen("testbench/stacker_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file testbench/stacker_patterns.txt");
      tests_failed++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", kw);
        if (n == 1) begin
          if (kw == "#") begin
            skip_line(fd);
          end else if (kw == "test") begin
            n = $fscanf(fd, "%s %d %d", test_name, pat_code, mode);
            sample_addr.delete();
            sample_data.delete();
            test_errors = 0;
          end else if (kw == "chunk") begin
            n = $fscanf(fd, "%d %h", addr, exp_data);
            sample_addr.push_back(stacker_pkg::chunk_addr_t'(addr));
            sample_data.push_back(exp_data);
          end else if (kw == "run") begin
            run_frame(stacker_pkg::pattern_e'(pat_code[1:0]), mode);
            report_test();
          end else begin
            $display("unknown keyword %s in the pattern file", kw);
            tests_failed++;
          end
        end
      end
      $fclose(fd);
    end
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    // reset check plus at least one frame
    if (tests_failed == 0 && tests_passed > 1) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // deadline moves forward with each frame
  initial begin : watchdog
    while (cycle_count <= deadline) begin
      @(posedge clk_camera);
    end
    $display("watchdog expired, test %s was still running at cycle %0d", test_name,
             cycle_count);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: design/pattern_stacker.sv
// test-pattern frame writer top: scanner, pixel lanes and chunk assembler on clk_camera
`include "stacker_defines.svh"

module pattern_stacker (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     start_i,
  input  stacker_pkg::pattern_e    pattern_sel_i,
  input  logic                     credit_return_i,
  output logic                     chunk_valid_o,
  output stacker_pkg::chunk_t      chunk_data_o,
  output stacker_pkg::chunk_addr_t chunk_addr_o,
  output logic                     chunk_last_o,
  output logic                     frame_done_o,
  output logic                     busy_o
);

  // scanner outputs
  logic                     issue_valid;
  stacker_pkg::coord_x_t    issue_x;
  stacker_pkg::coord_y_t    issue_y;
  stacker_pkg::chunk_addr_t issue_addr;
  logic                     issue_last;
  stacker_pkg::pattern_e    pattern;

  // lane outputs
  logic [`LANES-1:0]        lane_valid;
  stacker_pkg::rgb888_t     lane_pixels [`LANES];

  chunk_scanner scanner0 (
    .clk_camera      (clk_camera),
    .recent_reset    (recent_reset),
    .start_i         (start_i),
    .pattern_sel_i   (pattern_sel_i),
    .credit_return_i (credit_return_i),
    .issue_valid_o   (issue_valid),
    .issue_x_o       (issue_x),
    .issue_y_o       (issue_y),
    .issue_addr_o    (issue_addr),
    .issue_last_o    (issue_last),
    .pattern_o       (pattern),
    .busy_o          (busy_o)
  );

  // one lane per pixel of the chunk
  for (genvar k = 0; k < `LANES; k++) begin : g_lane
    pattern_lane #(
      .LANE_INDEX (k)
    ) lane (
      .clk_camera    (clk_camera),
      .recent_reset  (recent_reset),
      .issue_valid_i (issue_valid),
      .issue_x_i     (issue_x),
      .issue_y_i     (issue_y),
      .pattern_i     (pattern),
      .pixel_valid_o (lane_valid[k]),
      .pixel_o       (lane_pixels[k])
    );
  end

  // lanes run in lockstep, so the valids agree
  chunk_assembler assembler0 (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .lane_valid_i  (&lane_valid),
    .lane_pixels_i (lane_pixels),
    .issue_addr_i  (issue_addr),
    .issue_last_i  (issue_last),
    .chunk_valid_o (chunk_valid_o),
    .chunk_data_o  (chunk_data_o),
    .chunk_addr_o  (chunk_addr_o),
    .chunk_last_o  (chunk_last_o),
    .frame_done_o  (frame_done_o)
  );

endmodule

// File: design/chunk_assembler.sv
// packs the lane pixels into an RGB565 chunk and registers it with address and last
`include "stacker_defines.svh"

module chunk_assembler (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     lane_valid_i,
  input  stacker_pkg::rgb888_t     lane_pixels_i [`LANES],
  input  stacker_pkg::chunk_addr_t issue_addr_i,
  input  logic                     issue_last_i,
  output logic                     chunk_valid_o,
  output stacker_pkg::chunk_t      chunk_data_o,
  output stacker_pkg::chunk_addr_t chunk_addr_o,
  output logic                     chunk_last_o,
  output logic                     frame_done_o
);

  localparam int PIX_W = $bits(stacker_pkg::pixel565_t);

  stacker_pkg::chunk_addr_t addr_q;
  stacker_pkg::chunk_t      chunk_d;
  logic                     last_q;

  // keep the top bits of each component
  function automatic stacker_pkg::pixel565_t to_565(input stacker_pkg::rgb888_t p);
    return {p[stacker_pkg::CH_R][7:3], p[stacker_pkg::CH_G][7:2], p[stacker_pkg::CH_B][7:3]};
  endfunction

  // lane k lands in bits 16k+15 down to 16k
  always_comb begin
    chunk_d = '0;
    for (int k = 0; k < `LANES; k++) begin
      chunk_d[k*PIX_W +: PIX_W] = to_565(lane_pixels_i[k]);
    end
  end

  // address and last wait one cycle for the lane stage
  always_ff @(posedge clk_camera) begin
    addr_q <= issue_addr_i;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      last_q <= 1'b0;
    end else begin
      last_q <= issue_last_i;
    end
  end

  // output stage
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      frame_done_o  <= 1'b0;
    end else begin
      chunk_valid_o <= lane_valid_i;
      chunk_last_o  <= lane_valid_i && last_q;
      // single pulse, rides on the final chunk
      frame_done_o  <= lane_valid_i && last_q;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (lane_valid_i) begin
      chunk_data_o <= chunk_d;
      chunk_addr_o <= addr_q;
    end
  end

  // last flag from the scanner must arrive with the final chunk number
  last_addr_a : assert property (@(posedge clk_camera) disable iff (recent_reset)
    chunk_last_o |-> chunk_valid_o &&
                     (chunk_addr_o == stacker_pkg::chunk_addr_t'(`CHUNKS_PER_FRAME - 1)));

endmodule

// File: design/pattern_lane.sv
// one pixel of the current chunk: evaluates the selected pattern and registers it
`include "stacker_defines.svh"

module pattern_lane #(
  parameter int LANE_INDEX = 0
) (
  input  logic                  clk_camera,
  input  logic                  recent_reset,
  input  logic                  issue_valid_i,
  input  stacker_pkg::coord_x_t issue_x_i,
  input  stacker_pkg::coord_y_t issue_y_i,
  input  stacker_pkg::pattern_e pattern_i,
  output logic                  pixel_valid_o,
  output stacker_pkg::rgb888_t  pixel_o
);

  // eight colour bars across the frame
  localparam int BAR_W = `FB_HRES / 8;

  stacker_pkg::coord_x_t pix_x;
  stacker_pkg::rgb888_t  pix_d;
  logic [2:0]            bar;
  logic                  check;

  if (LANE_INDEX >= `LANES) begin : g_bad_index
    $error("pattern_lane LANE_INDEX beyond lane count");
  end

  // this lane's own column inside the chunk
  assign pix_x = issue_x_i + stacker_pkg::coord_x_t'(LANE_INDEX);

  // bar index by threshold compare, no divider
  always_comb begin
    bar = '0;
    for (int b = 1; b < 8; b++) begin
      if (pix_x >= stacker_pkg::coord_x_t'(b * BAR_W)) begin
        bar = 3'(b);
      end
    end
  end

  // 16 pixel squares
  assign check = pix_x[4] ^ issue_y_i[4];

  always_comb begin
    pix_d = '0;
    case (pattern_i)
      stacker_pkg::PAT_BARS: begin
        pix_d[stacker_pkg::CH_R] = {8{bar[2]}};
        pix_d[stacker_pkg::CH_G] = {8{bar[1]}};
        pix_d[stacker_pkg::CH_B] = {8{bar[0]}};
      end
      stacker_pkg::PAT_GRADIENT: begin
        // red wraps every 256 columns
        pix_d[stacker_pkg::CH_R] = pix_x[7:0];
        pix_d[stacker_pkg::CH_G] = issue_y_i;
      end
      stacker_pkg::PAT_CHECKER: begin
        pix_d = {24{check}};
      end
      stacker_pkg::PAT_SOLID: begin
        pix_d[stacker_pkg::CH_R] = 8'hff;
      end
      default: pix_d = '0;
    endcase
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pixel_valid_o <= 1'b0;
    end else begin
      pixel_valid_o <= issue_valid_i;
    end
  end

  // only load on a real issue
  always_ff @(posedge clk_camera) begin
    if (issue_valid_i) begin
      pixel_o <= pix_d;
    end
  end

endmodule

// File: design/chunk_scanner.sv
// walks the frame in chunk order under sink credits and drives the lanes and assembler
`include "stacker_defines.svh"

module chunk_scanner (
  input  logic                     clk_camera,
  input  logic                     recent_reset,
  input  logic                     start_i,
  input  stacker_pkg::pattern_e    pattern_sel_i,
  input  logic                     credit_return_i,
  output logic                     issue_valid_o,
  output stacker_pkg::coord_x_t    issue_x_o,
  output stacker_pkg::coord_y_t    issue_y_o,
  output stacker_pkg::chunk_addr_t issue_addr_o,
  output logic                     issue_last_o,
  output stacker_pkg::pattern_e    pattern_o,
  output logic                     busy_o
);

  localparam int COL_W    = $clog2(`CHUNK_COLS);
  localparam int CREDIT_W = $clog2(`CHUNK_CREDITS + 1);

  stacker_pkg::scan_state_e state_q;
  stacker_pkg::pattern_e    pattern_q;
  stacker_pkg::coord_y_t    row_q;
  stacker_pkg::chunk_addr_t addr_q;
  logic [COL_W-1:0]         col_q;
  logic [CREDIT_W-1:0]      credits_q;
  logic [CREDIT_W-1:0]      credits_d;
  logic                     drain_q;
  logic                     issue;
  logic                     at_last;
  logic                     row_end;

  assign at_last = addr_q == stacker_pkg::chunk_addr_t'(`CHUNKS_PER_FRAME - 1);
  assign row_end = col_q == COL_W'(`CHUNK_COLS - 1);

  // a credit returning this cycle may be spent at once
  assign issue = (state_q == stacker_pkg::SCAN_RUN) && ((credits_q != '0) || credit_return_i);

  assign issue_valid_o = issue;
  // first pixel column of the chunk
  assign issue_x_o     = stacker_pkg::coord_x_t'(col_q * `LANES);
  assign issue_y_o     = row_q;
  assign issue_addr_o  = addr_q;
  assign issue_last_o  = issue && at_last;
  assign pattern_o     = pattern_q;
  assign busy_o        = state_q != stacker_pkg::SCAN_IDLE;

  // credit count spent on issue and refilled by the sink
  always_comb begin
    credits_d = credits_q;
    if (credit_return_i && !issue) begin
      credits_d = credits_q + 1'b1;
    end else if (!credit_return_i && issue) begin
      credits_d = credits_q - 1'b1;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      state_q   <= stacker_pkg::SCAN_IDLE;
      col_q     <= '0;
      row_q     <= '0;
      addr_q    <= '0;
      credits_q <= CREDIT_W'(`CHUNK_CREDITS);
      drain_q   <= 1'b0;
    end else begin
      credits_q <= credits_d;
      case (state_q)
        stacker_pkg::SCAN_IDLE: begin
          // start only counts here, so a start while busy is dropped
          if (start_i) begin
            state_q <= stacker_pkg::SCAN_RUN;
          end
        end
        stacker_pkg::SCAN_RUN: begin
          if (issue) begin
            addr_q <= addr_q + 1'b1;
            if (row_end) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
            end else begin
              col_q <= col_q + 1'b1;
            end
            // rewind for the next frame after the last chunk
            if (at_last) begin
              state_q <= stacker_pkg::SCAN_DRAIN;
              addr_q  <= '0;
              row_q   <= '0;
              drain_q <= 1'b0;
            end
          end
        end
        stacker_pkg::SCAN_DRAIN: begin
          // two cycles for the lane and assembler stages
          drain_q <= 1'b1;
          if (drain_q) begin
            state_q <= stacker_pkg::SCAN_IDLE;
          end
        end
        default: state_q <= stacker_pkg::SCAN_IDLE;
      endcase
    end
  end

  // pattern held for the whole frame
  always_ff @(posedge clk_camera) begin
    if (state_q == stacker_pkg::SCAN_IDLE && start_i) begin
      pattern_q <= pattern_sel_i;
    end
  end

  // sink must never hand back more than it was given
  credit_bound_a : assert property (@(posedge clk_camera) disable iff (recent_reset)
    credits_q <= CREDIT_W'(`CHUNK_CREDITS));

  // an issue on zero credits spends the credit returning with it
  issue_credit_a : assert property (@(posedge clk_camera) disable iff (recent_reset)
    issue_valid_o && (credits_q == '0) |=> credits_q == '0);

endmodule

// File: design/stacker_pkg.sv
// shared pattern, state, coordinate and pixel types for the pattern stacker
`include "stacker_defines.svh"

package stacker_pkg;

  // test patterns, selected at start
  typedef enum logic [1:0] {
    PAT_BARS     = 2'd0,
    PAT_GRADIENT = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_SOLID    = 2'd3
  } pattern_e;

  // scanner FSM
  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_RUN,
    SCAN_DRAIN
  } scan_state_e;

  // pixel coordinates and chunk number
  typedef logic [$clog2(`FB_HRES)-1:0] coord_x_t;
  typedef logic [$clog2(`FB_VRES)-1:0] coord_y_t;
  typedef logic [$clog2(`CHUNKS_PER_FRAME)-1:0] chunk_addr_t;

  // component slots inside rgb888_t
  localparam int unsigned CH_R = 2;
  localparam int unsigned CH_G = 1;
  localparam int unsigned CH_B = 0;

  typedef logic [2:0][7:0] rgb888_t;
  typedef logic [15:0] pixel565_t;
  typedef logic [`CHUNK_W-1:0] chunk_t;

endpackage

// File: design/stacker_defines.svh
// frame geometry, lane count and credit depth macros; include in RTL and testbench
`ifndef STACKER_DEFINES_SVH
`define STACKER_DEFINES_SVH

// frame size in pixels
`define FB_HRES 320
`define FB_VRES 180

// pixels packed into one chunk
`define LANES 8

// chunk payload width, one RGB565 pixel per lane
`define CHUNK_W (`LANES * 16)

// chunks per row, and per frame
`define CHUNK_COLS (`FB_HRES / `LANES)
`define CHUNKS_PER_FRAME (`CHUNK_COLS * `FB_VRES)

// credits the sink grants after reset
// one credit per chunk it can absorb
`define CHUNK_CREDITS 4

`endif
